// ==== design/fetch_pkg.sv ====
package fetch_pkg;

  // Cache geometry
  localparam int WAY_CNT      = 2;
  localparam int SET_CNT      = 64;
  localparam int LINE_WORDS   = 4;
  localparam int IDX_LEN      = $clog2(SET_CNT);
  localparam int OFS_LEN      = $clog2(LINE_WORDS * 4);
  localparam int TAG_LEN      = 32 - IDX_LEN - OFS_LEN;
  localparam int UNCACHED_BIT = 31;
  localparam int DATA_DEPTH   = SET_CNT * LINE_WORDS / 2; // Two words per data row

  // Fetch queue
  localparam int Q_DEPTH = 4;
  localparam int Q_PTR_W = $clog2(Q_DEPTH);

  // Bus burst length codes
  localparam int                 BURST_W    = 4;
  localparam logic [BURST_W-1:0] BURST_LINE = 4'd3; // Four beats
  localparam logic [BURST_W-1:0] BURST_WORD = 4'd0;

  // Skid FSM encoding
  localparam int                 STATE_W    = 3;
  localparam logic [STATE_W-1:0] ST_NORMAL  = 3'd0;
  localparam logic [STATE_W-1:0] ST_RFADDR  = 3'd1;
  localparam logic [STATE_W-1:0] ST_RFDATA  = 3'd2;
  localparam logic [STATE_W-1:0] ST_UCADDR0 = 3'd3;
  localparam logic [STATE_W-1:0] ST_UCADDR1 = 3'd4;
  localparam logic [STATE_W-1:0] ST_UCDATA0 = 3'd5;
  localparam logic [STATE_W-1:0] ST_UCDATA1 = 3'd6;
  localparam logic [STATE_W-1:0] ST_RECOVER = 3'd7;

  typedef union packed {
    struct packed {
      logic [TAG_LEN-1:0]            tag;
      logic [IDX_LEN-1:0]            index;
      logic [$clog2(LINE_WORDS)-1:0] word;
      logic [1:0]                    byte_ofs;
    } fields;
    logic [31:0] raw;
  } fetch_addr_u;

  typedef struct packed {
    logic               valid;
    logic [TAG_LEN-1:0] tag;
  } itag_t;

endpackage

// ==== design/sync_spram.sv ====
`timescale 1ns/1ps

module sync_spram #(
  parameter int DATA_WIDTH = 64,
  parameter int DEPTH      = 128,
  parameter int LANE_WIDTH = 32
) (
  input  logic                               clk,
  input  logic [$clog2(DEPTH)-1:0]           addr_i,
  input  logic                               en_i,
  input  logic [DATA_WIDTH/LANE_WIDTH-1:0]   we_i,
  input  logic [DATA_WIDTH-1:0]              wdata_i,
  output logic [DATA_WIDTH-1:0]              rdata_o
);

  logic [DATA_WIDTH/LANE_WIDTH-1:0][LANE_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (en_i) begin
      rdata_o <= mem[addr_i]; // Old data on a write cycle
      for (int l = 0; l < DATA_WIDTH / LANE_WIDTH; l++) begin
        if (we_i[l]) begin
          mem[addr_i][l] <= wdata_i[l*LANE_WIDTH +: LANE_WIDTH];
        end
      end
    end
  end

endmodule

// ==== design/fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,
  output logic        pc_valid_o,
  output logic [31:0] pc_o,
  output logic [1:0]  pc_slot_o,
  input  logic        pc_ready_i
);

  logic [31:0] pc_d;
  logic [1:0]  slot_d;
  logic        advance;

  assign advance = pc_valid_o && pc_ready_i;

  always_comb begin
    pc_d   = pc_o;
    slot_d = pc_slot_o;
    if (redirect_i) begin
      pc_d   = {redirect_pc_i[31:3], 3'b000};
      // Odd-word target leaves only the upper slot
      slot_d = {1'b1, ~redirect_pc_i[2]};
    end else if (advance) begin
      pc_d   = pc_o + 32'd8;
      slot_d = 2'b11;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_valid_o <= 1'b0;
    end else begin
      pc_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_o      <= '0; // Boot address
      pc_slot_o <= 2'b11;
    end else begin
      pc_o      <= pc_d;
      pc_slot_o <= slot_d;
    end
  end

endmodule

// ==== design/icache_fetch.sv ====
`timescale 1ns/1ps

module icache_fetch (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  input  logic                          pc_valid_i,
  input  logic [31:0]                   pc_i,
  input  logic [1:0]                    pc_slot_i,
  output logic                          npc_ready_o,
  output logic [1:0]                    pkt_valid_o,
  output logic [31:0]                   pkt_pc_o,
  output logic [1:0][31:0]              pkt_inst_o,
  input  logic                          pkt_ready_i,
  output logic                          bus_req_valid_o,
  output logic [31:0]                   bus_req_addr_o,
  output logic [fetch_pkg::BURST_W-1:0] bus_req_burst_o,
  input  logic                          bus_req_ready_i,
  input  logic                          bus_rdata_valid_i,
  input  logic [31:0]                   bus_rdata_i
);

  import fetch_pkg::*;

  fetch_addr_u              f1_pc, f2_pc_q, skid_pc_q, req_addr;
  logic [1:0]               f2_valid_q;
  logic                     sweep_busy_q;
  logic [IDX_LEN-1:0]       sweep_cnt_q;
  logic                     skid_busy_q;
  logic [1:0]               skid_valid_q;
  logic                     skid_hit_q;
  logic [1:0][31:0]         skid_data_q;
  logic [WAY_CNT-1:0]       skid_way_q;
  logic [WAY_CNT-1:0]       victim_q;
  logic [STATE_W-1:0]       state_q;
  logic [1:0]               refill_cnt_q;
  itag_t [WAY_CNT-1:0]      tag_rdata;
  itag_t                    tag_wdata;
  logic [WAY_CNT-1:0][63:0] data_rdata;
  logic [WAY_CNT-1:0]       tag_we, data_we, hits;
  logic [IDX_LEN-1:0]       tag_addr;
  logic [IDX_LEN:0]         data_addr;
  logic                     ram_en, f2_hit, need_skid, refill_beat, refill_last;
  logic [1:0][31:0]         sel_data;

  assign f1_pc       = fetch_addr_u'(pc_i);
  assign npc_ready_o = !skid_busy_q && !sweep_busy_q;

  // F1 to F2 register
  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      f2_valid_q <= '0;
    end else if (npc_ready_o) begin
      f2_valid_q <= pc_valid_i ? pc_slot_i : 2'b00;
    end
  end

  always_ff @(posedge clk) begin
    if (npc_ready_o) begin
      f2_pc_q <= f1_pc;
    end
  end

  // Tag invalidation after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sweep_busy_q <= 1'b1;
      sweep_cnt_q  <= '0;
    end else if (sweep_busy_q) begin
      sweep_cnt_q <= sweep_cnt_q + 1'b1;
      if (sweep_cnt_q == IDX_LEN'(SET_CNT - 1)) begin
        sweep_busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      victim_q <= WAY_CNT'(1);
    end else begin
      victim_q <= {victim_q[WAY_CNT-2:0], victim_q[WAY_CNT-1]};
    end
  end

  // RAMs idle while waiting on the bus
  assign ram_en = sweep_busy_q || !skid_busy_q || state_q == ST_RFDATA ||
                  state_q == ST_RECOVER;

  always_comb begin
    if (sweep_busy_q) begin
      tag_addr = sweep_cnt_q;
    end else if (state_q == ST_RFDATA) begin
      tag_addr = skid_pc_q.fields.index;
    end else if (npc_ready_o) begin
      tag_addr = f1_pc.fields.index;
    end else begin
      tag_addr = f2_pc_q.fields.index; // Re-read F2 line before leaving skid
    end
  end

  always_comb begin
    if (state_q == ST_RFDATA) begin
      data_addr = {skid_pc_q.fields.index, refill_cnt_q[1]};
    end else if (npc_ready_o) begin
      data_addr = {f1_pc.fields.index, f1_pc.fields.word[1]};
    end else begin
      data_addr = {f2_pc_q.fields.index, f2_pc_q.fields.word[1]};
    end
  end

  assign refill_beat     = (state_q == ST_RFDATA) && bus_rdata_valid_i;
  assign refill_last     = refill_beat && (&refill_cnt_q);
  assign tag_wdata.valid = !sweep_busy_q;
  assign tag_wdata.tag   = skid_pc_q.fields.tag;
  assign tag_we          = sweep_busy_q ? '1 : (skid_way_q & {WAY_CNT{refill_last}});
  assign data_we         = skid_way_q & {WAY_CNT{refill_beat}};

  for (genvar w = 0; w < WAY_CNT; w++) begin : g_way
    sync_spram #(
      .DATA_WIDTH ($bits(itag_t)),
      .DEPTH      (SET_CNT),
      .LANE_WIDTH ($bits(itag_t))
    ) u_tag (
      .clk     (clk),
      .addr_i  (tag_addr),
      .en_i    (ram_en),
      .we_i    (tag_we[w]),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[w])
    );

    sync_spram #(
      .DATA_WIDTH (64),
      .DEPTH      (DATA_DEPTH),
      .LANE_WIDTH (32)
    ) u_data (
      .clk     (clk),
      .addr_i  (data_addr),
      .en_i    (ram_en),
      .we_i    ({data_we[w] & refill_cnt_q[0], data_we[w] & ~refill_cnt_q[0]}),
      .wdata_i ({bus_rdata_i, bus_rdata_i}),
      .rdata_o (data_rdata[w])
    );

    assign hits[w] = tag_rdata[w].valid && (tag_rdata[w].tag == f2_pc_q.fields.tag);
  end

  always_comb begin
    sel_data = data_rdata[0];
    for (int w = 1; w < WAY_CNT; w++) begin
      if (hits[w]) begin
        sel_data = data_rdata[w];
      end
    end
  end

  assign f2_hit    = (|hits) && !f2_pc_q.raw[UNCACHED_BIT];
  assign need_skid = !flush_i && (|f2_valid_q) && (!f2_hit || !pkt_ready_i);

  // Skid register follows F2 until it takes over
  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      skid_valid_q <= '0;
    end else if (!skid_busy_q) begin
      skid_valid_q <= f2_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!skid_busy_q) begin
      skid_pc_q   <= f2_pc_q;
      skid_hit_q  <= f2_hit;
      skid_way_q  <= victim_q;
      skid_data_q <= sel_data;
    end else begin
      if (refill_beat && refill_cnt_q[1] == skid_pc_q.fields.word[1]) begin
        skid_data_q[refill_cnt_q[0]] <= bus_rdata_i;
      end
      if (state_q == ST_UCDATA0 && bus_rdata_valid_i) begin
        skid_data_q[0] <= bus_rdata_i;
      end
      if (state_q == ST_UCDATA1 && bus_rdata_valid_i) begin
        skid_data_q[1] <= bus_rdata_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || state_q != ST_RFDATA) begin
      refill_cnt_q <= '0;
    end else if (bus_rdata_valid_i) begin
      refill_cnt_q <= refill_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= ST_NORMAL;
      skid_busy_q <= 1'b0;
    end else if (!skid_busy_q) begin
      if (need_skid) begin
        skid_busy_q <= 1'b1;
      end
    end else begin
      case (state_q)
        ST_NORMAL: begin
          if (skid_hit_q || skid_valid_q == 2'b00) begin
            state_q <= ST_RECOVER; // Queue was full, or packet flushed
          end else if (skid_pc_q.raw[UNCACHED_BIT]) begin
            state_q <= skid_valid_q[0] ? ST_UCADDR0 : ST_UCADDR1;
          end else begin
            state_q <= ST_RFADDR;
          end
        end
        ST_RFADDR: if (bus_req_ready_i) state_q <= ST_RFDATA;
        ST_RFDATA: if (refill_last) state_q <= ST_RECOVER;
        ST_UCADDR0: if (bus_req_ready_i) state_q <= ST_UCDATA0;
        ST_UCADDR1: if (bus_req_ready_i) state_q <= ST_UCDATA1;
        ST_UCDATA0: begin
          if (bus_rdata_valid_i) begin
            state_q <= skid_valid_q[1] ? ST_UCADDR1 : ST_RECOVER;
          end
        end
        ST_UCDATA1: if (bus_rdata_valid_i) state_q <= ST_RECOVER;
        ST_RECOVER: begin
          if (pkt_ready_i) begin
            state_q     <= ST_NORMAL;
            skid_busy_q <= 1'b0;
          end
        end
      endcase
    end
  end

  always_comb begin
    req_addr                 = skid_pc_q;
    req_addr.fields.byte_ofs = '0;
    bus_req_valid_o          = 1'b0;
    bus_req_burst_o          = BURST_WORD;
    case (state_q)
      ST_RFADDR: begin
        bus_req_valid_o      = 1'b1;
        bus_req_burst_o      = BURST_LINE;
        req_addr.fields.word = '0; // Line base
      end
      ST_UCADDR0: begin
        bus_req_valid_o         = 1'b1;
        req_addr.fields.word[0] = 1'b0;
      end
      ST_UCADDR1: begin
        bus_req_valid_o         = 1'b1;
        req_addr.fields.word[0] = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign bus_req_addr_o = req_addr.raw;

  assign pkt_valid_o = skid_busy_q ? (state_q == ST_RECOVER ? skid_valid_q : 2'b00)
                                   : (f2_hit ? f2_valid_q : 2'b00);
  assign pkt_pc_o    = skid_busy_q ? skid_pc_q.raw : f2_pc_q.raw;
  assign pkt_inst_o  = skid_busy_q ? skid_data_q : sel_data;

endmodule

// ==== design/fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic [1:0]       in_valid_i,
  input  logic [31:0]      in_pc_i,
  input  logic [1:0][31:0] in_inst_i,
  output logic             in_ready_o,
  output logic             out_valid_o,
  output logic [31:0]      out_pc_o,
  output logic [1:0][31:0] out_inst_o,
  output logic [1:0]       out_slot_o,
  input  logic             out_ready_i
);

  import fetch_pkg::*;

  logic [Q_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [Q_PTR_W:0]   count_q;
  logic [31:0]        pc_mem   [Q_DEPTH];
  logic [1:0][31:0]   inst_mem [Q_DEPTH];
  logic [1:0]         slot_mem [Q_DEPTH];
  logic               push, pop;

  assign in_ready_o  = count_q < Q_DEPTH;
  assign out_valid_o = count_q != '0;
  assign push        = (|in_valid_i) && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  assign out_pc_o   = pc_mem[rd_ptr_q];
  assign out_inst_o = inst_mem[rd_ptr_q];
  assign out_slot_o = slot_mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push) begin
      pc_mem[wr_ptr_q]   <= in_pc_i;
      inst_mem[wr_ptr_q] <= in_inst_i;
      slot_mem[wr_ptr_q] <= in_valid_i;
    end
  end

  // Flush empties the queue and drops any write in that cycle
  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1; // Wraps at depth
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== design/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          redirect_i,
  input  logic [31:0]                   redirect_pc_i,
  output logic                          bus_req_valid_o,
  output logic [31:0]                   bus_req_addr_o,
  output logic [fetch_pkg::BURST_W-1:0] bus_req_burst_o,
  input  logic                          bus_req_ready_i,
  input  logic                          bus_rdata_valid_i,
  input  logic [31:0]                   bus_rdata_i,
  output logic                          inst_valid_o,
  output logic [31:0]                   inst_pc_o,
  output logic [1:0][31:0]              inst_o,
  output logic [1:0]                    inst_slot_o,
  input  logic                          inst_ready_i
);

  logic             pc_valid;
  logic [31:0]      pc;
  logic [1:0]       pc_slot;
  logic             npc_ready;
  logic [1:0]       pkt_valid;
  logic [31:0]      pkt_pc;
  logic [1:0][31:0] pkt_inst;
  logic             pkt_ready;

  fetch_pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_valid_o    (pc_valid),
    .pc_o          (pc),
    .pc_slot_o     (pc_slot),
    .pc_ready_i    (npc_ready)
  );

  icache_fetch u_icache (
    .clk               (clk),
    .rst_n             (rst_n),
    .flush_i           (redirect_i),
    .pc_valid_i        (pc_valid),
    .pc_i              (pc),
    .pc_slot_i         (pc_slot),
    .npc_ready_o       (npc_ready),
    .pkt_valid_o       (pkt_valid),
    .pkt_pc_o          (pkt_pc),
    .pkt_inst_o        (pkt_inst),
    .pkt_ready_i       (pkt_ready),
    .bus_req_valid_o   (bus_req_valid_o),
    .bus_req_addr_o    (bus_req_addr_o),
    .bus_req_burst_o   (bus_req_burst_o),
    .bus_req_ready_i   (bus_req_ready_i),
    .bus_rdata_valid_i (bus_rdata_valid_i),
    .bus_rdata_i       (bus_rdata_i)
  );

  fetch_queue u_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (redirect_i),
    .in_valid_i  (pkt_valid),
    .in_pc_i     (pkt_pc),
    .in_inst_i   (pkt_inst),
    .in_ready_o  (pkt_ready),
    .out_valid_o (inst_valid_o),
    .out_pc_o    (inst_pc_o),
    .out_inst_o  (inst_o),
    .out_slot_o  (inst_slot_o),
    .out_ready_i (inst_ready_i)
  );

endmodule

// ==== tests/fetch_mem_model.sv ====
`timescale 1ns/1ps

module fetch_mem_model (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          req_valid_i,
  input  logic [31:0]                   req_addr_i,
  input  logic [fetch_pkg::BURST_W-1:0] req_burst_i,
  output logic                          req_ready_o,
  output logic                          rdata_valid_o,
  output logic [31:0]                   rdata_o
);

  int seed = 5833;

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return addr ^ 32'h5A5A_0000;
  endfunction

  // Zero to three idle cycles
  task automatic idle_gap();
    int gap;
    gap = $random(seed) & 3;
    repeat (gap) @(negedge clk);
  endtask

  initial begin
    logic [31:0] addr;
    int          beats;
    req_ready_o   = 1'b0;
    rdata_valid_o = 1'b0;
    rdata_o       = '0;
    forever begin
      @(negedge clk);
      if (rst_n && req_valid_i) begin
        idle_gap();
        req_ready_o = 1'b1;
        addr        = req_addr_i;
        beats       = int'(req_burst_i) + 1; // Code 3 means four beats
        @(negedge clk);
        req_ready_o = 1'b0;
        for (int b = 0; b < beats; b++) begin
          idle_gap();
          rdata_valid_o = 1'b1;
          rdata_o       = word_at(addr + 32'(4 * b));
          @(negedge clk);
          rdata_valid_o = 1'b0;
        end
      end
    end
  end

endmodule

// ==== tests/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch;

  import fetch_pkg::*;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               redirect;
  logic [31:0]        redirect_pc;
  logic               bus_req_valid;
  logic [31:0]        bus_req_addr;
  logic [BURST_W-1:0] bus_req_burst;
  logic               bus_req_ready;
  logic               bus_rdata_valid;
  logic [31:0]        bus_rdata;
  logic               inst_valid;
  logic [31:0]        inst_pc;
  logic [1:0][31:0]   inst;
  logic [1:0]         inst_slot;
  logic               inst_ready;

  int seed         = 5833;
  int errors       = 0;
  int err_mark     = 0;
  int tests_failed = 0;
  int cyc          = 0;
  int pkt_cnt      = 0;
  int uc_req_cnt   = 0;
  int uc_base      = 0;
  int uc_need      = 0;
  int n_seq        = 16;
  int n_uc         = 4;
  int n_bp         = 24;
  int n_redir      = 4;

  logic             take, boot_win;
  logic [31:0]      exp_pc;
  logic [1:0]       exp_slot;
  logic             hold_q;
  logic [31:0]      held_pc_q;
  logic [1:0][31:0] held_inst_q;
  logic [1:0]       held_slot_q;
  logic             second_pass  = 1'b0;
  logic             uc_check     = 1'b0;
  logic             random_ready = 1'b0;

  always #20 clk = ~clk;

  fetch_top uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .redirect_i        (redirect),
    .redirect_pc_i     (redirect_pc),
    .bus_req_valid_o   (bus_req_valid),
    .bus_req_addr_o    (bus_req_addr),
    .bus_req_burst_o   (bus_req_burst),
    .bus_req_ready_i   (bus_req_ready),
    .bus_rdata_valid_i (bus_rdata_valid),
    .bus_rdata_i       (bus_rdata),
    .inst_valid_o      (inst_valid),
    .inst_pc_o         (inst_pc),
    .inst_o            (inst),
    .inst_slot_o       (inst_slot),
    .inst_ready_i      (inst_ready)
  );

  fetch_mem_model u_mem (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (bus_req_valid),
    .req_addr_i    (bus_req_addr),
    .req_burst_i   (bus_req_burst),
    .req_ready_o   (bus_req_ready),
    .rdata_valid_o (bus_rdata_valid),
    .rdata_o       (bus_rdata)
  );

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ 32'h5A5A_0000;
  endfunction

  assign take     = inst_valid && inst_ready && !redirect;
  assign boot_win = cyc >= 1 && cyc < 80; // Reset plus 64 sweep cycles

  // Expected stream and bookkeeping
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (!rst_n) begin
      exp_pc   <= '0;
      exp_slot <= 2'b11;
      hold_q   <= 1'b0;
    end else begin
      if (redirect) begin
        exp_pc   <= redirect_pc & ~32'h7;
        exp_slot <= (redirect_pc[2:0] != 3'b000) ? 2'b10 : 2'b11;
      end else if (take) begin
        exp_pc   <= exp_pc + 32'd8;
        exp_slot <= 2'b11;
        pkt_cnt  <= pkt_cnt + 1;
      end
      hold_q <= inst_valid && !inst_ready && !redirect;
      if (bus_req_valid && bus_req_ready && bus_req_addr[31]) begin
        uc_req_cnt <= uc_req_cnt + 1;
      end
    end
    held_pc_q   <= inst_pc;
    held_inst_q <= inst;
    held_slot_q <= inst_slot;
  end

  // Decoder stall pattern
  always @(negedge clk) begin
    if (random_ready) begin
      inst_ready = 1'($random(seed) & 1);
    end
  end

  a_boot: assert property (@(posedge clk) boot_win |-> !inst_valid && !bus_req_valid)
    else begin
      errors++;
      $display("%0t: inst_valid_o or bus_req_valid_o raised during reset or tag sweep", $time);
    end

  a_pc: assert property (@(posedge clk) disable iff (!rst_n) take |-> inst_pc == exp_pc)
    else begin
      errors++;
      $display("mismatch at %0t: inst_pc_o got %h expected %h", $time,
               $sampled(inst_pc), $sampled(exp_pc));
    end

  a_slot: assert property (@(posedge clk) disable iff (!rst_n) take |-> inst_slot == exp_slot)
    else begin
      errors++;
      $display("mismatch at %0t: inst_slot_o got %b expected %b", $time,
               $sampled(inst_slot), $sampled(exp_slot));
    end

  a_inst0: assert property (@(posedge clk) disable iff (!rst_n)
                            take && exp_slot[0] |-> inst[0] == mem_word(exp_pc))
    else begin
      errors++;
      $display("mismatch at %0t: inst_o[0] got %h expected %h", $time,
               $sampled(inst[0]), mem_word($sampled(exp_pc)));
    end

  a_inst1: assert property (@(posedge clk) disable iff (!rst_n)
                            take && exp_slot[1] |-> inst[1] == mem_word(exp_pc + 32'd4))
    else begin
      errors++;
      $display("mismatch at %0t: inst_o[1] got %h expected %h", $time,
               $sampled(inst[1]), mem_word($sampled(exp_pc) + 32'd4));
    end

  a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n) hold_q |-> inst_valid)
    else begin
      errors++;
      $display("%0t: inst_valid_o dropped before the decoder took the packet", $time);
    end

  a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
                                hold_q |-> {inst_pc, inst, inst_slot} ==
                                           {held_pc_q, held_inst_q, held_slot_q})
    else begin
      errors++;
      $display("mismatch at %0t: inst_pc_o/inst_o/inst_slot_o got %h expected %h", $time,
               $sampled({inst_pc, inst, inst_slot}),
               $sampled({held_pc_q, held_inst_q, held_slot_q}));
    end

  a_line_burst: assert property (@(posedge clk) disable iff (!rst_n)
                                 bus_req_valid && !bus_req_addr[31] |->
                                 bus_req_burst == BURST_LINE)
    else begin
      errors++;
      $display("mismatch at %0t: bus_req_burst_o got %0d expected %0d", $time,
               $sampled(bus_req_burst), BURST_LINE);
    end

  a_line_base: assert property (@(posedge clk) disable iff (!rst_n)
                                bus_req_valid && !bus_req_addr[31] |-> bus_req_addr[3:0] == 4'h0)
    else begin
      errors++;
      $display("%0t: line refill request to %h is not at a line base", $time,
               $sampled(bus_req_addr));
    end

  a_word_burst: assert property (@(posedge clk) disable iff (!rst_n)
                                 bus_req_valid && bus_req_addr[31] |->
                                 bus_req_burst == BURST_WORD && bus_req_addr[1:0] == 2'b00)
    else begin
      errors++;
      $display("%0t: uncached request to %h is not a single aligned word", $time,
               $sampled(bus_req_addr));
    end

  a_no_refetch: assert property (@(posedge clk) disable iff (!rst_n)
                                 second_pass && bus_req_valid |-> bus_req_addr >= 32'h80)
    else begin
      errors++;
      $display("%0t: bus request to %h for a line that should hit", $time,
               $sampled(bus_req_addr));
    end

  a_uc_count: assert property (@(posedge clk) disable iff (!rst_n)
                               uc_check |-> uc_req_cnt - uc_base >= uc_need)
    else begin
      errors++;
      $display("%0t: only %0d single-word requests for %0d uncached slots", $time,
               $sampled(uc_req_cnt - uc_base), $sampled(uc_need));
    end

  task automatic redirect_to(input logic [31:0] target);
    redirect    = 1'b1;
    redirect_pc = target;
    @(negedge clk);
    redirect = 1'b0;
  endtask

  task automatic wait_packets(input int count);
    int base;
    base = pkt_cnt;
    while (pkt_cnt - base < count) begin
      @(negedge clk);
    end
  endtask

  task automatic uncached_pass();
    uc_base = uc_req_cnt;
    redirect_to(32'h8000_0000);
    wait_packets(n_uc);
    uc_need  = 2 * n_uc; // Both slots valid in every packet
    uc_check = 1'b1;
    @(negedge clk);
    uc_check = 1'b0;
  endtask

  task automatic end_test(input int num, input string name);
    if (errors == err_mark) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: failed, %0d errors", num, name, errors - err_mark);
      tests_failed++;
    end
    err_mark = errors;
  endtask

  initial begin
    rst_n       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    inst_ready  = 1'b1;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    repeat (64) @(negedge clk);
    end_test(1, "reset and tag sweep idle");
    wait_packets(n_seq);
    end_test(2, "sequential cached fetch");
    second_pass = 1'b1;
    redirect_to(32'h0);
    wait_packets(n_seq);
    second_pass = 1'b0;
    end_test(3, "second pass hits");
    uncached_pass();
    uncached_pass();
    end_test(4, "uncached single words");
    random_ready = 1'b1;
    redirect_to(32'h200);
    wait_packets(n_bp);
    end_test(5, "decoder back-pressure");
    redirect_to(32'h44); // Odd word in a cached line
    wait_packets(n_redir);
    end_test(6, "unaligned redirect");
    $display("%0d of 6 tests passed, %0d assertion failures", 6 - tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Forty cycles per packet plus reset and sweep
  initial begin
    repeat ((2 * n_seq + 2 * n_uc + n_bp + n_redir) * 40 + 16 + 64) @(posedge clk);
    $display("timeout: the fetch stream stalled before all tests finished");
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== verilog.f ====
design/fetch_pkg.sv
design/sync_spram.sv
design/fetch_pc_gen.sv
design/icache_fetch.sv
design/fetch_queue.sv
design/fetch_top.sv
tests/fetch_mem_model.sv
tests/tb_fetch.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - files:
      - design/fetch_pkg.sv
      - design/sync_spram.sv
      - design/fetch_pc_gen.sv
      - design/icache_fetch.sv
      - design/fetch_queue.sv
      - design/fetch_top.sv
  - target: test
    files:
      - tests/fetch_mem_model.sv
      - tests/tb_fetch.sv
